// File: hdl/periph_bus_pkg.sv
package periph_bus_pkg;

   // host bus widths
   localparam int HID_ADDR_W = 18;
   localparam int HID_DATA_W = 64;
   localparam int HID_BE_W   = 8;

   // slot field sits in address bits 17..15
   localparam int SLOT_W = 3;

   localparam logic [SLOT_W-1:0] SLOT_MISC = 3'd2;   // led and dip slot
   localparam logic [SLOT_W-1:0] SLOT_UART = 3'd6;   // uart fifos and status

   // misc slot words
   localparam logic [3:0] MISC_LED_WORD = 4'd15;     // write word, addr 6..3
   localparam logic [4:0] MISC_DIP_WORD = 5'd31;     // read word, addr 7..3

   localparam logic [31:0] MISC_FILL = 32'hDEADBEEF; // unmapped misc reads

endpackage

// File: hdl/uart_pkg.sv
package uart_pkg;

   localparam int BAUD_W = 16;
   localparam logic [BAUD_W-1:0] BAUD_DEFAULT = 16'd54;   // msoc_clk cycles per bit

   localparam int FIFO_DEPTH = 16;
   localparam int CNT_W      = 12;                        // running push/pop counts

   typedef logic [7:0] uart_byte_t;

   // receive fifo entry, error flag above the byte
   typedef struct packed {
      logic       err;
      uart_byte_t data;
   } rx_entry_t;

   typedef enum logic [2:0] {
      UTX_IDLE,
      UTX_EMPTY,
      UTX_POP,
      UTX_START,
      UTX_INUSE
   } utx_state_t;

   // write operation in addr 13..12
   localparam logic [1:0] UART_OP_TX   = 2'd0;
   localparam logic [1:0] UART_OP_POP  = 2'd1;
   localparam logic [1:0] UART_OP_BAUD = 2'd2;

endpackage

// File: hdl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo import uart_pkg::*;
#(
   parameter type payload_t = uart_byte_t,
   parameter int  DEPTH     = FIFO_DEPTH
)
(
   input  logic             msoc_clk,
   input  logic             rstn,
   input  logic             push_i,
   input  payload_t         din_i,
   input  logic             pop_i,
   output payload_t         dout_o,
   output logic             full_o,
   output logic             empty_o,
   output logic [CNT_W-1:0] wrcount_o,
   output logic [CNT_W-1:0] rdcount_o
);

   localparam int AW = $clog2(DEPTH);

   payload_t         mem [DEPTH];
   logic [CNT_W-1:0] wr_cnt_q, rd_cnt_q;
   logic [CNT_W-1:0] occ;
   logic             do_push, do_pop;

   assign occ     = wr_cnt_q - rd_cnt_q;      // counts wrap together
   assign full_o  = (occ == CNT_W'(DEPTH));
   assign empty_o = (occ == '0);
   assign do_push = push_i & ~full_o;         // dropped when full
   assign do_pop  = pop_i & ~empty_o;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wr_cnt_q <= '0;
         rd_cnt_q <= '0;
      end
      else
      begin
         if (do_push)
            wr_cnt_q <= wr_cnt_q + 1'b1;
         if (do_pop)
            rd_cnt_q <= rd_cnt_q + 1'b1;
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (do_push)
         mem[wr_cnt_q[AW-1:0]] <= din_i;
   end

   assign dout_o    = mem[rd_cnt_q[AW-1:0]];  // fall-through head
   assign wrcount_o = wr_cnt_q;
   assign rdcount_o = rd_cnt_q;

   a_occ_bound: assert property (@(posedge msoc_clk) disable iff (!rstn)
      occ <= CNT_W'(DEPTH));

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import uart_pkg::*;
(
   input  logic              msoc_clk,
   input  logic              rstn,
   input  logic [BAUD_W-1:0] baud_i,
   input  logic              start_i,
   input  uart_byte_t        byte_i,
   output logic              tx_o,
   output logic              busy_o
);

   logic [BAUD_W-1:0] cnt_q;
   logic [3:0]        left_q;                   // bits still to go after the current one
   logic [8:0]        shift_q;                  // data then stop
   logic              bit_end;

   assign bit_end = busy_o && (cnt_q == '0);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         tx_o   <= 1'b1;                         // line idles high
         busy_o <= 1'b0;
         cnt_q  <= '0;
         left_q <= '0;
      end
      else if (!busy_o)
      begin
         if (start_i)
         begin
            tx_o   <= 1'b0;                      // start bit
            busy_o <= 1'b1;
            cnt_q  <= baud_i - 1'b1;
            left_q <= 4'd9;
         end
      end
      else if (!bit_end)
         cnt_q <= cnt_q - 1'b1;
      else if (left_q == '0)
         busy_o <= 1'b0;                         // stop bit done
      else
      begin
         tx_o   <= shift_q[0];
         cnt_q  <= baud_i - 1'b1;
         left_q <= left_q - 1'b1;
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (!busy_o && start_i)
         shift_q <= {1'b1, byte_i};
      else if (bit_end)
         shift_q <= {1'b1, shift_q[8:1]};        // lsb first
   end

endmodule

// File: hdl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_pkg::*;
(
   input  logic              msoc_clk,
   input  logic              rstn,
   input  logic [BAUD_W-1:0] baud_i,
   input  logic              rx_i,
   output logic              valid_o,
   output uart_byte_t        byte_o,
   output logic              err_o
);

   logic [2:0]        samp_q;                   // majority window
   logic              maj, maj_prev_q;
   logic              active_q;
   logic [BAUD_W-1:0] cnt_q;
   logic [3:0]        idx_q;                    // 0 start, 1..8 data, 9 stop
   logic              mid_bit;

   assign maj = (samp_q[0] & samp_q[1]) | (samp_q[0] & samp_q[2]) |
                (samp_q[1] & samp_q[2]);
   assign mid_bit = active_q && (cnt_q == '0);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         samp_q     <= 3'b111;
         maj_prev_q <= 1'b1;
         active_q   <= 1'b0;
         cnt_q      <= '0;
         idx_q      <= '0;
         valid_o    <= 1'b0;
      end
      else
      begin
         samp_q     <= {samp_q[1:0], rx_i};
         maj_prev_q <= maj;
         valid_o    <= 1'b0;
         if (!active_q)
         begin
            if (maj_prev_q && !maj)              // falling edge, start bit
            begin
               active_q <= 1'b1;
               cnt_q    <= baud_i >> 1;
               idx_q    <= '0;
            end
         end
         else if (!mid_bit)
            cnt_q <= cnt_q - 1'b1;
         else
         begin
            cnt_q <= baud_i - 1'b1;
            idx_q <= idx_q + 1'b1;
            if ((idx_q == 4'd0) && maj)
               active_q <= 1'b0;                 // glitch, not a start bit
            else if (idx_q == 4'd9)
            begin
               active_q <= 1'b0;
               valid_o  <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (mid_bit && (idx_q >= 4'd1) && (idx_q <= 4'd8))
         byte_o <= {maj, byte_o[7:1]};
      if (mid_bit && (idx_q == 4'd9))
         err_o <= ~maj;                          // stop bit low
   end

endmodule

// File: hdl/uart_regs.sv
`timescale 1ns/1ps

module uart_regs import periph_bus_pkg::*, uart_pkg::*;
(
   input  logic                  msoc_clk,
   input  logic                  rstn,
   input  logic                  uart_sel_i,
   input  logic [HID_BE_W-1:0]   hid_we_i,
   input  logic [HID_ADDR_W-1:0] hid_addr_i,
   input  logic [HID_DATA_W-1:0] hid_wrdata_i,
   output logic [HID_DATA_W-1:0] rdata_o,
   output logic                  tx_push_o,
   output uart_byte_t            tx_data_o,
   output logic                  tx_pop_o,
   input  uart_byte_t            tx_head_i,
   input  logic                  tx_full_i,
   input  logic                  tx_empty_i,
   input  logic [CNT_W-1:0]      tx_wrcount_i,
   input  logic [CNT_W-1:0]      tx_rdcount_i,
   output logic                  rx_pop_o,
   input  rx_entry_t             rx_head_i,
   input  logic                  rx_full_i,
   input  logic                  rx_empty_i,
   input  logic [CNT_W-1:0]      rx_wrcount_i,
   input  logic [CNT_W-1:0]      rx_rdcount_i,
   output logic [BAUD_W-1:0]     baud_o,
   output logic                  tx_start_o,
   output uart_byte_t            tx_byte_o,
   input  logic                  tx_busy_i,
   output logic                  irq_o
);

   localparam int PAD = 16 - CNT_W;

   logic       wr_en;
   logic [1:0] op;
   utx_state_t state_q, state_d;
   uart_byte_t tx_byte_q;

   assign wr_en     = uart_sel_i & (|hid_we_i) & hid_addr_i[14];
   assign op        = hid_addr_i[13:12];
   assign tx_push_o = wr_en && (op == UART_OP_TX);
   assign tx_data_o = hid_wrdata_i[7:0];
   assign rx_pop_o  = wr_en && (op == UART_OP_POP);
   assign irq_o     = ~rx_empty_i;             // level while rx data waits

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         baud_o  <= BAUD_DEFAULT;
         state_q <= UTX_IDLE;
      end
      else
      begin
         state_q <= state_d;
         if (wr_en && (op == UART_OP_BAUD))
            baud_o <= hid_wrdata_i[BAUD_W-1:0];
      end
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         UTX_IDLE:  state_d = UTX_EMPTY;
         UTX_EMPTY: if (!tx_empty_i) state_d = UTX_POP;
         UTX_POP:   state_d = UTX_START;
         UTX_START: state_d = UTX_INUSE;
         UTX_INUSE: if (!tx_busy_i) state_d = UTX_IDLE;
         default:   state_d = UTX_IDLE;
      endcase
   end

   always_ff @(posedge msoc_clk)
   begin
      if (state_q == UTX_POP)
         tx_byte_q <= tx_head_i;               // head still valid before the pop lands
   end

   assign tx_pop_o   = (state_q == UTX_POP);
   assign tx_start_o = (state_q == UTX_START);
   assign tx_byte_o  = tx_byte_q;

   // bit 14 low is the old keyboard window
   always_comb
   begin
      if (!hid_addr_i[14])
         rdata_o = '0;
      else if (hid_addr_i[13])
         rdata_o = {{PAD{1'b0}}, tx_wrcount_i, {PAD{1'b0}}, tx_rdcount_i,
                    {PAD{1'b0}}, rx_wrcount_i, {PAD{1'b0}}, rx_rdcount_i};
      else
         rdata_o = {{(HID_DATA_W-3-$bits(rx_entry_t)){1'b0}},
                    rx_full_i, tx_full_i, rx_empty_i, rx_head_i};
   end

   a_pop_nonempty: assert property (@(posedge msoc_clk) disable iff (!rstn)
      tx_pop_o |-> !tx_empty_i);

endmodule

// File: hdl/periph_decode.sv
`timescale 1ns/1ps

module periph_decode import periph_bus_pkg::*;
(
   input  logic                  msoc_clk,
   input  logic                  rstn,
   input  logic                  hid_en_i,
   input  logic [HID_BE_W-1:0]   hid_we_i,
   input  logic [HID_ADDR_W-1:0] hid_addr_i,
   input  logic [HID_DATA_W-1:0] hid_wrdata_i,
   input  logic [15:0]           from_dip_i,
   input  logic [HID_DATA_W-1:0] uart_rdata_i,
   output logic                  uart_sel_o,
   output logic [HID_DATA_W-1:0] hid_rddata_o,
   output logic [7:0]            to_led_o
);

   localparam int NSLOT = 2 ** SLOT_W;

   logic [SLOT_W-1:0]     slot;
   logic [NSLOT-1:0]      slot_hit;                  // one-hot, address only
   logic                  led_wr;
   logic [15:0]           dip_q;
   logic [HID_DATA_W-1:0] misc_rdata;
   logic [HID_DATA_W-1:0] slot_rdata [NSLOT];

   assign slot       = hid_addr_i[HID_ADDR_W-1 -: SLOT_W];
   assign slot_hit   = NSLOT'(1) << slot;
   assign uart_sel_o = hid_en_i & slot_hit[SLOT_UART];
   assign led_wr     = hid_en_i & (|hid_we_i) & slot_hit[SLOT_MISC] &
                       (hid_addr_i[6:3] == MISC_LED_WORD);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         to_led_o <= '0;
         dip_q    <= '0;
      end
      else
      begin
         dip_q <= from_dip_i;                        // one cycle behind the pins
         if (led_wr)
            to_led_o <= hid_wrdata_i[7:0];
      end
   end

   assign misc_rdata = (hid_addr_i[7:3] == MISC_DIP_WORD) ?
                       {{(HID_DATA_W-16){1'b0}}, dip_q} :
                       {{(HID_DATA_W-32){1'b0}}, MISC_FILL};

   // read merge, slots without a peripheral read zero
   always_comb
   begin
      slot_rdata = '{default: '0};
      slot_rdata[SLOT_MISC] = misc_rdata;
      slot_rdata[SLOT_UART] = uart_rdata_i;
      hid_rddata_o = '0;
      for (int i = 0; i < NSLOT; i++)
      begin
         if (slot_hit[i])
            hid_rddata_o = hid_rddata_o | slot_rdata[i];
      end
   end

endmodule

// File: hdl/periph_soc_top.sv
`timescale 1ns/1ps

module periph_soc_top import periph_bus_pkg::*, uart_pkg::*;
(
   input  logic                  msoc_clk,
   input  logic                  rstn,
   input  logic                  hid_en_i,
   input  logic [HID_BE_W-1:0]   hid_we_i,
   input  logic [HID_ADDR_W-1:0] hid_addr_i,
   input  logic [HID_DATA_W-1:0] hid_wrdata_i,
   output logic [HID_DATA_W-1:0] hid_rddata_o,
   input  logic                  uart_rx_i,
   output logic                  uart_tx_o,
   output logic                  uart_irq_o,
   output logic [7:0]            to_led_o,
   input  logic [15:0]           from_dip_i
);

   logic                  uart_sel;
   logic [HID_DATA_W-1:0] uart_rdata;
   logic [BAUD_W-1:0]     baud;

   logic                  tx_push, tx_pop, tx_full, tx_empty;
   uart_byte_t            tx_din, tx_head, tx_byte;
   logic [CNT_W-1:0]      tx_wrcount, tx_rdcount;
   logic                  tx_start, tx_busy;

   logic                  rx_pop, rx_full, rx_empty;
   rx_entry_t             rx_din, rx_head;
   logic [CNT_W-1:0]      rx_wrcount, rx_rdcount;
   logic                  rx_valid, rx_err;
   uart_byte_t            rx_byte;

   assign rx_din.err  = rx_err;
   assign rx_din.data = rx_byte;

   periph_decode u_decode (
      .msoc_clk(msoc_clk), .rstn(rstn),
      .hid_en_i(hid_en_i), .hid_we_i(hid_we_i), .hid_addr_i(hid_addr_i),
      .hid_wrdata_i(hid_wrdata_i), .from_dip_i(from_dip_i), .uart_rdata_i(uart_rdata),
      .uart_sel_o(uart_sel), .hid_rddata_o(hid_rddata_o), .to_led_o(to_led_o)
   );

   uart_regs u_regs (
      .msoc_clk(msoc_clk), .rstn(rstn),
      .uart_sel_i(uart_sel), .hid_we_i(hid_we_i), .hid_addr_i(hid_addr_i),
      .hid_wrdata_i(hid_wrdata_i), .rdata_o(uart_rdata),
      .tx_push_o(tx_push), .tx_data_o(tx_din), .tx_pop_o(tx_pop), .tx_head_i(tx_head),
      .tx_full_i(tx_full), .tx_empty_i(tx_empty),
      .tx_wrcount_i(tx_wrcount), .tx_rdcount_i(tx_rdcount),
      .rx_pop_o(rx_pop), .rx_head_i(rx_head), .rx_full_i(rx_full), .rx_empty_i(rx_empty),
      .rx_wrcount_i(rx_wrcount), .rx_rdcount_i(rx_rdcount),
      .baud_o(baud), .tx_start_o(tx_start), .tx_byte_o(tx_byte), .tx_busy_i(tx_busy),
      .irq_o(uart_irq_o)
   );

   sync_fifo #(.payload_t(uart_byte_t), .DEPTH(FIFO_DEPTH)) u_tx_fifo (
      .msoc_clk(msoc_clk), .rstn(rstn),
      .push_i(tx_push), .din_i(tx_din), .pop_i(tx_pop), .dout_o(tx_head),
      .full_o(tx_full), .empty_o(tx_empty), .wrcount_o(tx_wrcount), .rdcount_o(tx_rdcount)
   );

   sync_fifo #(.payload_t(rx_entry_t), .DEPTH(FIFO_DEPTH)) u_rx_fifo (
      .msoc_clk(msoc_clk), .rstn(rstn),
      .push_i(rx_valid), .din_i(rx_din), .pop_i(rx_pop), .dout_o(rx_head),
      .full_o(rx_full), .empty_o(rx_empty), .wrcount_o(rx_wrcount), .rdcount_o(rx_rdcount)
   );

   uart_tx u_tx (
      .msoc_clk(msoc_clk), .rstn(rstn), .baud_i(baud), .start_i(tx_start),
      .byte_i(tx_byte), .tx_o(uart_tx_o), .busy_o(tx_busy)
   );

   uart_rx u_rx (
      .msoc_clk(msoc_clk), .rstn(rstn), .baud_i(baud), .rx_i(uart_rx_i),
      .valid_o(rx_valid), .byte_o(rx_byte), .err_o(rx_err)
   );

endmodule

// File: bench/tb_periph_soc.sv
`timescale 1ns/1ps

module tb_periph_soc import periph_bus_pkg::*, uart_pkg::*; ();

   localparam int CLK_NS       = 4;
   localparam int RESET_CYCLES = 8;
   localparam int BAUD         = 8;                    // bit period written to the DUT
   localparam int STIM_WORDS   = 96;

   localparam logic [15:0] OP_END     = 16'h0;
   localparam logic [15:0] OP_DIP     = 16'h1;
   localparam logic [15:0] OP_TX      = 16'h2;
   localparam logic [15:0] OP_RX_GOOD = 16'h3;
   localparam logic [15:0] OP_RX_BAD  = 16'h4;
   localparam logic [15:0] OP_FLOOD   = 16'h5;

   localparam logic [1:0] RD_STATUS = 2'b00;           // addr 13 low
   localparam logic [1:0] RD_COUNTS = 2'b10;           // addr 13 high
   localparam logic [7:0] FLOOD_BASE = 8'ha0;

   logic                  msoc_clk;
   logic                  rstn;
   logic                  hid_en;
   logic [HID_BE_W-1:0]   hid_we;
   logic [HID_ADDR_W-1:0] hid_addr;
   logic [HID_DATA_W-1:0] hid_wrdata;
   logic [HID_DATA_W-1:0] hid_rddata;
   logic                  uart_rx;
   logic                  uart_tx;
   logic                  uart_irq;
   logic [7:0]            to_led;
   logic [15:0]           from_dip;

   logic [15:0] stim [STIM_WORDS];                     // op, value, expected
   uart_byte_t  tx_expect [$];
   uart_byte_t  tx_seen [$];                           // frames caught on uart_tx_o
   integer      seed;
   int          checks, errors, timeouts;
   int          tx_total, rx_pushed, rx_popped;
   int          frames, wd_limit;
   logic        stim_loaded;

   periph_soc_top DUT (
      .msoc_clk(msoc_clk),
      .rstn(rstn),
      .hid_en_i(hid_en),
      .hid_we_i(hid_we),
      .hid_addr_i(hid_addr),
      .hid_wrdata_i(hid_wrdata),
      .hid_rddata_o(hid_rddata),
      .uart_rx_i(uart_rx),
      .uart_tx_o(uart_tx),
      .uart_irq_o(uart_irq),
      .to_led_o(to_led),
      .from_dip_i(from_dip)
   );

   initial
   begin
      msoc_clk = 1'b0;
      forever
         #(CLK_NS / 2) msoc_clk = ~msoc_clk;
   end

   function automatic logic [HID_ADDR_W-1:0] uart_addr(input logic [1:0] op);
      logic [HID_ADDR_W-1:0] a;
      a = '0;
      a[HID_ADDR_W-1 -: SLOT_W] = SLOT_UART;
      a[14]    = 1'b1;
      a[13:12] = op;
      return a;
   endfunction

   function automatic logic [HID_ADDR_W-1:0] misc_addr(input logic [4:0] word);
      logic [HID_ADDR_W-1:0] a;
      a = '0;
      a[HID_ADDR_W-1 -: SLOT_W] = SLOT_MISC;
      a[7:3] = word;
      return a;
   endfunction

   task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic host_write(input logic [HID_ADDR_W-1:0] addr, input logic [15:0] value);
      logic [63:0] fill;
      fill = {$random(seed), $random(seed)};         // junk above the used field
      @(posedge msoc_clk);
      #1;
      hid_en     = 1'b1;
      hid_we     = '1;
      hid_addr   = addr;
      hid_wrdata = {fill[63:16], value};
      @(posedge msoc_clk);
      #1;
      hid_en = 1'b0;
      hid_we = '0;
   endtask

   task automatic host_read(input logic [HID_ADDR_W-1:0] addr, output logic [63:0] data);
      @(posedge msoc_clk);
      #1;
      hid_en   = 1'b1;
      hid_we   = '0;
      hid_addr = addr;
      #1;
      data = hid_rddata;                              // zero-latency read
      @(posedge msoc_clk);
      #1;
      hid_en = 1'b0;
   endtask

   task automatic wait_irq(input logic level);
      int n;
      n = 0;
      while ((uart_irq !== level) && (n < 40 * BAUD))
      begin
         @(posedge msoc_clk);
         #1;
         n++;
      end
      if (uart_irq !== level)
      begin
         timeouts++;
         $display("timed out waiting for uart_irq_o to become %0d", level);
      end
   endtask

   // 8N1 frame onto uart_rx_i
   task automatic send_frame(input uart_byte_t b, input logic stop_bit);
      logic [9:0] bits;
      bits = {stop_bit, b, 1'b0};
      @(posedge msoc_clk);
      #1;
      for (int i = 0; i < 10; i++)
      begin
         uart_rx = bits[i];
         repeat (BAUD) @(posedge msoc_clk);
         #1;
      end
      uart_rx = 1'b1;
      if (!stop_bit)
         repeat (BAUD) @(posedge msoc_clk);         // idle so the next start edge is seen
   endtask

   task automatic watch_tx_line();
      uart_byte_t b;
      forever
      begin
         @(negedge uart_tx);
         repeat (BAUD / 2) @(negedge msoc_clk);       // middle of the start bit
         if (uart_tx !== 1'b0)
         begin
            errors++;
            $display("start bit on uart_tx_o did not stay low to its middle");
         end
         for (int i = 0; i < 8; i++)
         begin
            repeat (BAUD) @(negedge msoc_clk);
            b[i] = uart_tx;
         end
         repeat (BAUD) @(negedge msoc_clk);
         expect_eq("uart_tx_o stop bit", 64'(uart_tx), 64'h1);
         tx_seen.push_back(b);
      end
   endtask

   task automatic flush_tx();
      logic [63:0] rd;
      int n;
      n = 0;
      while ((tx_seen.size() < tx_expect.size()) && (n < (tx_expect.size() + 1) * 12 * BAUD))
      begin
         @(posedge msoc_clk);
         n++;
      end
      if (tx_seen.size() < tx_expect.size())
      begin
         timeouts++;
         $display("timed out waiting for frames on uart_tx_o");
      end
      while ((tx_expect.size() > 0) && (tx_seen.size() > 0))
         expect_eq("uart_tx_o byte", 64'(tx_seen.pop_front()), 64'(tx_expect.pop_front()));
      if (tx_seen.size() > 0)
      begin
         errors++;
         $display("more frames on uart_tx_o than bytes written");
      end
      tx_expect.delete();
      tx_seen.delete();
      host_read(uart_addr(RD_COUNTS), rd);
      expect_eq("tx wrcount", 64'(rd[59:48]), 64'(tx_total));
      expect_eq("tx rdcount", 64'(rd[43:32]), 64'(tx_total));
   endtask

   task automatic check_dip(input logic [15:0] value, input logic [15:0] exp);
      logic [63:0] rd;
      @(posedge msoc_clk);
      #1;
      from_dip = value;
      host_read(misc_addr(5'(MISC_DIP_WORD)), rd);   // one edge passes first
      expect_eq("dip word", rd, 64'(exp));
   endtask

   task automatic receive_one(input uart_byte_t b, input logic stop_bit, input logic [15:0] exp);
      logic [63:0] rd;
      send_frame(b, stop_bit);
      rx_pushed++;
      wait_irq(1'b1);
      host_read(uart_addr(RD_STATUS), rd);
      expect_eq("rx head entry", 64'(rd[8:0]), 64'(exp[8:0]));
      expect_eq("rx_empty", 64'(rd[9]), 64'h0);
      host_write(uart_addr(UART_OP_POP), 16'h0);
      rx_popped++;
      wait_irq(1'b0);
      host_read(uart_addr(RD_STATUS), rd);
      expect_eq("rx_empty", 64'(rd[9]), 64'h1);
   endtask

   task automatic receive_flood(input int count, input int kept);
      logic [63:0] rd;
      for (int i = 0; i < count; i++)
         send_frame(FLOOD_BASE + 8'(i), 1'b1);
      rx_pushed = rx_pushed + kept;                   // overflow frames are dropped
      wait_irq(1'b1);
      host_read(uart_addr(RD_STATUS), rd);
      expect_eq("rx_full", 64'(rd[11]), 64'h1);
      host_read(uart_addr(RD_COUNTS), rd);
      expect_eq("rx wrcount", 64'(rd[27:16]), 64'(rx_pushed));
      expect_eq("rx rdcount", 64'(rd[11:0]), 64'(rx_popped));
      for (int i = 0; i < kept; i++)
      begin
         host_read(uart_addr(RD_STATUS), rd);
         expect_eq("rx head entry", 64'(rd[8:0]), 64'({1'b0, FLOOD_BASE + 8'(i)}));
         host_write(uart_addr(UART_OP_POP), 16'h0);
      end
      rx_popped = rx_popped + kept;
      wait_irq(1'b0);
      host_read(uart_addr(RD_STATUS), rd);
      expect_eq("rx_empty", 64'(rd[9]), 64'h1);
   endtask

   initial
   begin
      wait (stim_loaded === 1'b1);
      #(wd_limit);
      $display("watchdog expired after %0d ns, the run did not finish", wd_limit);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial
   begin
      wait (rstn === 1'b1);
      watch_tx_line();
   end

   initial
   begin
      logic [63:0]           rd;
      logic [15:0]           op, val, exp;
      logic [HID_ADDR_W-1:0] kbd_addr;
      int                    k;
      seed        = 26239;
      checks      = 0;
      errors      = 0;
      timeouts    = 0;
      tx_total    = 0;
      rx_pushed   = 0;
      rx_popped   = 0;
      stim_loaded = 1'b0;
      rstn        = 1'b0;
      hid_en      = 1'b0;
      hid_we      = '0;
      hid_addr    = '0;
      hid_wrdata  = '0;
      uart_rx     = 1'b1;                             // line idles high
      from_dip    = '0;

      $readmemh("bench/uart_stimulus.dat", stim);
      k      = 0;
      frames = 0;
      while ((k + 2 < STIM_WORDS) && (stim[k] != OP_END))
      begin
         if (stim[k] == OP_FLOOD)
            frames = frames + int'(stim[k + 1]);
         else if (stim[k] != OP_DIP)
            frames++;
         k = k + 3;
      end
      wd_limit    = frames * 10 * BAUD * CLK_NS * 3 + RESET_CYCLES * CLK_NS;
      stim_loaded = 1'b1;

      repeat (RESET_CYCLES) @(posedge msoc_clk);
      #1;
      rstn = 1'b1;

      expect_eq("uart_tx_o", 64'(uart_tx), 64'h1);
      expect_eq("uart_irq_o", 64'(uart_irq), 64'h0);
      expect_eq("to_led_o", 64'(to_led), 64'h0);
      host_read(uart_addr(RD_STATUS), rd);
      expect_eq("status flags", 64'(rd[11:9]), 64'h1);
      host_read(uart_addr(RD_COUNTS), rd);
      expect_eq("count word", rd, 64'h0);

      host_write(misc_addr(5'(MISC_LED_WORD)), 16'h00c3);
      expect_eq("to_led_o", 64'(to_led), 64'hc3);
      host_read(misc_addr(5'd5), rd);
      expect_eq("misc word 5", rd, 64'hdeadbeef);
      kbd_addr     = uart_addr(RD_STATUS);
      kbd_addr[14] = 1'b0;                            // old keyboard window
      host_read(kbd_addr, rd);
      expect_eq("keyboard window", rd, 64'h0);

      host_write(uart_addr(UART_OP_BAUD), 16'(BAUD));

      k = 0;
      while ((k + 2 < STIM_WORDS) && (stim[k] != OP_END))
      begin
         op  = stim[k];
         val = stim[k + 1];
         exp = stim[k + 2];
         k   = k + 3;
         if ((op != OP_TX) && (tx_expect.size() > 0))
            flush_tx();
         case (op)
            OP_DIP:
               check_dip(val, exp);
            OP_TX:
            begin
               host_write(uart_addr(UART_OP_TX), val);
               tx_expect.push_back(exp[7:0]);
               tx_total++;
            end
            OP_RX_GOOD:
               receive_one(val[7:0], 1'b1, exp);
            OP_RX_BAD:
               receive_one(val[7:0], 1'b0, exp);
            OP_FLOOD:
               receive_flood(int'(val), int'(exp));
            default:
            begin
               errors++;
               $display("unknown opcode %h in the stimulus file", op);
            end
         endcase
      end
      if (tx_expect.size() > 0)
         flush_tx();

      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if ((errors == 0) && (timeouts == 0))
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// File: bench/uart_stimulus.dat
// columns: op value expected, all hex
// op 1 dip value/readback, 2 tx byte/line byte, 3 rx good, 4 rx bad, 5 flood frames/kept, 0 end
1 a55a a55a
1 0f3c 0f3c
1 ffff ffff
2 0055 0055
2 00a3 00a3
2 0001 0001
2 0080 0080
2 00fe 00fe
3 005c 005c
4 00c7 01c7
3 0000 0000
4 00ff 01ff
3 00e1 00e1
1 1234 1234
2 0039 0039
2 00c6 00c6
5 0012 0010
0 0000 0000

// File: build.f
hdl/periph_bus_pkg.sv
hdl/uart_pkg.sv
hdl/sync_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_regs.sv
hdl/periph_decode.sv
hdl/periph_soc_top.sv
bench/tb_periph_soc.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_periph_soc
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
